// File: hw/rsc_core.sv
`timescale 1ns/1ps
`default_nettype none

module rsc_core (
    input  wire logic           i_clk,
    input  wire logic           i_rst,
    input  wire rsc_pkg::word_t i_inst,
    output rsc_pkg::word_t      o_pc,
    input  wire rsc_pkg::word_t i_mem_rd_data,
    output rsc_pkg::word_t      o_mem_addr,
    output rsc_pkg::word_t      o_mem_wr_data,
    output logic                o_mem_wr_en
);

    // Stage registers
    rsc_pkg::if_id_t   w_if_id;
    rsc_pkg::id_ex_t   w_id_ex;
    rsc_pkg::ex_mem_t  w_ex_mem;
    rsc_pkg::mem_wb_t  w_wb;

    // Register file ports
    rsc_pkg::reg_idx_t w_rd_idx1;
    rsc_pkg::reg_idx_t w_rd_idx2;
    rsc_pkg::word_t    w_rd_data1;
    rsc_pkg::word_t    w_rd_data2;
    logic              w_reg_wr_en;

    // Memory stage result, also forwarded
    rsc_pkg::word_t    w_mem_result;
    rsc_pkg::reg_idx_t w_mem_tgt;
    rsc_pkg::word_t    w_jalr_target;

    // Pipeline control
    logic              w_hold_fetch;
    logic              w_bubble_fetch;
    logic              w_hold_decode;
    logic              w_bubble_decode;
    logic              w_bubble_exec;

    rsc_fetch u_fetch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_inst        (i_inst),
        .i_hold        (w_hold_fetch),
        .i_bubble      (w_bubble_fetch),
        .i_ex_mem      (w_ex_mem),
        .i_id_ex       (w_id_ex),
        .i_jalr_target (w_jalr_target),
        .o_pc          (o_pc),
        .o_if_id       (w_if_id)
    );

    rsc_decode u_decode (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_if_id    (w_if_id),
        .i_hold     (w_hold_decode),
        .i_bubble   (w_bubble_decode),
        .i_wb       (w_wb),
        .o_rd_idx1  (w_rd_idx1),
        .o_rd_idx2  (w_rd_idx2),
        .i_rd_data1 (w_rd_data1),
        .i_rd_data2 (w_rd_data2),
        .o_id_ex    (w_id_ex)
    );

    rsc_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rd_idx1  (w_rd_idx1),
        .i_rd_idx2  (w_rd_idx2),
        .o_rd_data1 (w_rd_data1),
        .o_rd_data2 (w_rd_data2),
        .i_wr_en    (w_reg_wr_en),
        .i_wr_idx   (w_mem_tgt),
        .i_wr_data  (w_mem_result)
    );

    rsc_execute u_execute (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_id_ex       (w_id_ex),
        .i_bubble      (w_bubble_exec),
        .i_mem_result  (w_mem_result),
        .i_mem_tgt     (w_mem_tgt),
        .i_wb          (w_wb),
        .o_jalr_target (w_jalr_target),
        .o_ex_mem      (w_ex_mem)
    );

    rsc_mem_wb u_mem_wb (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ex_mem      (w_ex_mem),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .o_mem_result  (w_mem_result),
        .o_mem_tgt     (w_mem_tgt),
        .o_reg_wr_en   (w_reg_wr_en),
        .o_wb          (w_wb)
    );

    rsc_hazard_ctrl u_hazard_ctrl (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_if_id         (w_if_id),
        .i_id_ex         (w_id_ex),
        .i_ex_mem        (w_ex_mem),
        .o_hold_fetch    (w_hold_fetch),
        .o_bubble_fetch  (w_bubble_fetch),
        .o_hold_decode   (w_hold_decode),
        .o_bubble_decode (w_bubble_decode),
        .o_bubble_exec   (w_bubble_exec)
    );

endmodule

`default_nettype wire

// File: hw/rsc_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsc_macros.svh"

module rsc_decode (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire rsc_pkg::if_id_t  i_if_id,
    input  wire logic             i_hold,
    input  wire logic             i_bubble,
    input  wire rsc_pkg::mem_wb_t i_wb,
    output rsc_pkg::reg_idx_t     o_rd_idx1,
    output rsc_pkg::reg_idx_t     o_rd_idx2,
    input  wire rsc_pkg::word_t   i_rd_data1,
    input  wire rsc_pkg::word_t   i_rd_data2,
    output rsc_pkg::id_ex_t       o_id_ex
);

    rsc_pkg::opcode_e  w_opcode;
    rsc_pkg::reg_idx_t w_ra;
    rsc_pkg::reg_idx_t w_rb;
    rsc_pkg::reg_idx_t w_rc;
    rsc_pkg::word_t    w_simm_ext;
    rsc_pkg::word_t    w_limm_ext;
    rsc_pkg::reg_idx_t w_tgt;
    rsc_pkg::reg_idx_t w_src1;
    rsc_pkg::reg_idx_t w_src2;
    rsc_pkg::word_t    w_imm;

    // --------------------------------------------------
    // Field split and immediates
    // --------------------------------------------------
    assign w_opcode = rsc_pkg::opcode_e'(i_if_id.inst[`RSC_OP_LSB +: `RSC_OP_W]);
    assign w_ra     = i_if_id.inst[`RSC_RA_LSB +: `RSC_REG_IDX_W];
    assign w_rb     = i_if_id.inst[`RSC_RB_LSB +: `RSC_REG_IDX_W];
    assign w_rc     = i_if_id.inst[`RSC_RC_LSB +: `RSC_REG_IDX_W];

    assign w_simm_ext = {{(`RSC_WORD_W - `RSC_SIMM_W){i_if_id.inst[`RSC_SIMM_W-1]}},
                         i_if_id.inst[`RSC_SIMM_W-1:0]};
    assign w_limm_ext = {i_if_id.inst[`RSC_LIMM_W-1:0], {(`RSC_WORD_W - `RSC_LIMM_W){1'b0}}};

    always_comb begin
        w_tgt  = '0;
        w_src1 = '0;
        w_src2 = '0;
        w_imm  = '0;
        case (w_opcode)
            rsc_pkg::OP_ADD, rsc_pkg::OP_NAND: begin
                w_tgt  = w_ra;
                w_src1 = w_rb;
                w_src2 = w_rc;
            end
            rsc_pkg::OP_ADDI, rsc_pkg::OP_LW: begin
                w_tgt  = w_ra;
                w_src1 = w_rb;       // Base or addend
                w_imm  = w_simm_ext;
            end
            rsc_pkg::OP_LUI: begin
                w_tgt = w_ra;
                w_imm = w_limm_ext;
            end
            rsc_pkg::OP_SW, rsc_pkg::OP_BEQ: begin
                w_src1 = w_rb;
                w_src2 = w_ra;       // Store value or compare operand
                w_imm  = w_simm_ext;
            end
            rsc_pkg::OP_JALR: begin
                w_tgt  = w_ra;       // Link register
                w_src1 = w_rb;
            end
            default: ;
        endcase
    end

    assign o_rd_idx1 = w_src1;
    assign o_rd_idx2 = w_src2;

    // --------------------------------------------------
    // Decode/execute register
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex.valid <= 1'b0;
        end else if (i_hold) begin
            // Catch the write-back value before it leaves the pipe
            if (i_wb.valid && i_wb.tgt != '0 && i_wb.tgt == o_id_ex.src1)
                o_id_ex.opnd1 <= i_wb.result;
            if (i_wb.valid && i_wb.tgt != '0 && i_wb.tgt == o_id_ex.src2)
                o_id_ex.opnd2 <= i_wb.result;
        end else if (i_bubble) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= '{valid: i_if_id.valid, pc: i_if_id.pc, opcode: w_opcode,
                         tgt: w_tgt, src1: w_src1, src2: w_src2,
                         opnd1: i_rd_data1, opnd2: i_rd_data2, imm: w_imm};
        end
    end

endmodule

`default_nettype wire

// File: hw/rsc_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rsc_execute (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire rsc_pkg::id_ex_t   i_id_ex,
    input  wire logic              i_bubble,
    input  wire rsc_pkg::word_t    i_mem_result,
    input  wire rsc_pkg::reg_idx_t i_mem_tgt,      // Zero when memory stage is empty
    input  wire rsc_pkg::mem_wb_t  i_wb,
    output rsc_pkg::word_t         o_jalr_target,
    output rsc_pkg::ex_mem_t       o_ex_mem
);

    rsc_pkg::word_t w_opnd1;
    rsc_pkg::word_t w_opnd2;
    rsc_pkg::word_t w_alu_a;
    rsc_pkg::word_t w_alu_b;
    rsc_pkg::word_t w_alu_out;
    logic           w_alu_nand;
    logic           w_alu_eq;

    // Newest producer wins
    function automatic rsc_pkg::word_t fwd_operand(input rsc_pkg::reg_idx_t src,
                                                   input rsc_pkg::word_t    rd_val);
        if (src == '0)
            return '0;
        if (o_ex_mem.valid && o_ex_mem.tgt == src)
            return o_ex_mem.alu_result;
        if (i_mem_tgt == src)
            return i_mem_result;
        if (i_wb.valid && i_wb.tgt == src)
            return i_wb.result;
        return rd_val;
    endfunction

    always_comb begin
        w_opnd1 = fwd_operand(i_id_ex.src1, i_id_ex.opnd1);
        w_opnd2 = fwd_operand(i_id_ex.src2, i_id_ex.opnd2);
    end

    assign o_jalr_target = w_opnd1;

    // --------------------------------------------------
    // ALU input and operation select
    // --------------------------------------------------
    always_comb begin
        w_alu_nand = 1'b0;
        w_alu_a    = w_opnd1;
        w_alu_b    = w_opnd2;              // ADD, and BEQ compare
        case (i_id_ex.opcode)
            rsc_pkg::OP_ADDI, rsc_pkg::OP_LUI,
            rsc_pkg::OP_SW, rsc_pkg::OP_LW: w_alu_b = i_id_ex.imm;
            rsc_pkg::OP_NAND: w_alu_nand = 1'b1;
            rsc_pkg::OP_JALR: begin
                w_alu_a = i_id_ex.pc + 1'b1;  // Link value
                w_alu_b = '0;
            end
            default: ;
        endcase
    end

    assign w_alu_out = w_alu_nand ? ~(w_alu_a & w_alu_b) : (w_alu_a + w_alu_b);
    assign w_alu_eq  = (w_alu_a == w_alu_b);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_mem.valid <= 1'b0;
        end else if (i_bubble) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem <= '{valid: i_id_ex.valid, pc: i_id_ex.pc, opcode: i_id_ex.opcode,
                          tgt: i_id_ex.tgt, alu_result: w_alu_out, st_data: w_opnd2,
                          eq: w_alu_eq, imm: i_id_ex.imm};
        end
    end

endmodule

`default_nettype wire

// File: hw/rsc_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsc_macros.svh"

module rsc_fetch (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire rsc_pkg::word_t   i_inst,
    input  wire logic             i_hold,
    input  wire logic             i_bubble,
    input  wire rsc_pkg::ex_mem_t i_ex_mem,
    input  wire rsc_pkg::id_ex_t  i_id_ex,
    input  wire rsc_pkg::word_t   i_jalr_target,
    output rsc_pkg::word_t        o_pc,
    output rsc_pkg::if_id_t       o_if_id
);

    rsc_pkg::word_t r_pc;          // Sequential next PC
    rsc_pkg::word_t w_pc_curr;     // Address fetched this cycle
    rsc_pkg::word_t w_br_target;

    // BEQ resolves from the execute/memory register
    assign w_br_target = i_ex_mem.pc + 1'b1 + (i_ex_mem.eq ? i_ex_mem.imm : '0);

    always_comb begin
        w_pc_curr = r_pc;
        if (i_ex_mem.valid && i_ex_mem.opcode == rsc_pkg::OP_BEQ) begin
            w_pc_curr = w_br_target;
        end else if (i_id_ex.valid && i_id_ex.opcode == rsc_pkg::OP_JALR) begin
            w_pc_curr = i_jalr_target;  // Forwarded base register
        end
    end

    assign o_pc = w_pc_curr;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pc          <= `RSC_RESET_PC;
            o_if_id.valid <= 1'b0;
        end else if (!i_hold) begin
            if (i_bubble) begin
                o_if_id.valid <= 1'b0;  // PC stays put
            end else begin
                r_pc    <= w_pc_curr + 1'b1;
                o_if_id <= '{valid: 1'b1, pc: w_pc_curr, inst: i_inst};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rsc_hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsc_macros.svh"

module rsc_hazard_ctrl (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire rsc_pkg::if_id_t  i_if_id,
    input  wire rsc_pkg::id_ex_t  i_id_ex,
    input  wire rsc_pkg::ex_mem_t i_ex_mem,
    output logic                  o_hold_fetch,
    output logic                  o_bubble_fetch,
    output logic                  o_hold_decode,
    output logic                  o_bubble_decode,
    output logic                  o_bubble_exec
);

    rsc_pkg::opcode_e w_if_opcode;
    logic             w_stall_fetch;
    logic             w_stall_decode;
    logic             w_stall_exec;

    assign w_if_opcode = rsc_pkg::opcode_e'(i_if_id.inst[`RSC_OP_LSB +: `RSC_OP_W]);

    // --------------------------------------------------
    // Stall origins
    // --------------------------------------------------
    // No wrong-path fetch behind a control transfer
    assign w_stall_fetch  = i_if_id.valid && (w_if_opcode == rsc_pkg::OP_BEQ ||
                                              w_if_opcode == rsc_pkg::OP_JALR);
    assign w_stall_decode = i_id_ex.valid && i_id_ex.opcode == rsc_pkg::OP_BEQ;

    // Load-use
    assign w_stall_exec = i_ex_mem.valid && i_id_ex.valid &&
                          i_ex_mem.opcode == rsc_pkg::OP_LW && i_ex_mem.tgt != '0 &&
                          (i_ex_mem.tgt == i_id_ex.src1 || i_ex_mem.tgt == i_id_ex.src2);

    // A stall holds every stage upstream of it
    assign o_bubble_exec   = w_stall_exec;
    assign o_hold_decode   = w_stall_exec;
    assign o_bubble_decode = w_stall_decode;
    assign o_hold_fetch    = w_stall_decode || w_stall_exec;
    assign o_bubble_fetch  = w_stall_fetch;

    a_load_use_bubble: assert property (@(posedge i_clk) disable iff (i_rst)
        w_stall_exec |=> !i_ex_mem.valid);

endmodule

`default_nettype wire

// File: hw/rsc_macros.svh
`ifndef RSC_MACROS_SVH
`define RSC_MACROS_SVH

// Datapath and register file widths
`define RSC_WORD_W     16
`define RSC_REG_IDX_W  3
`define RSC_NUM_REGS   8
`define RSC_OP_W       3

// Immediates
`define RSC_SIMM_W     7     // Sign-extended to a word
`define RSC_LIMM_W     10    // LUI, lands in the upper bits

// Field positions, LSB of each field
`define RSC_OP_LSB     13
`define RSC_RA_LSB     10
`define RSC_RB_LSB     7
`define RSC_RC_LSB     0

`define RSC_RESET_PC   16'h0000

`endif

// File: hw/rsc_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rsc_mem_wb (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire rsc_pkg::ex_mem_t i_ex_mem,
    input  wire rsc_pkg::word_t   i_mem_rd_data,
    output rsc_pkg::word_t        o_mem_addr,
    output rsc_pkg::word_t        o_mem_wr_data,
    output logic                  o_mem_wr_en,
    output rsc_pkg::word_t        o_mem_result,
    output rsc_pkg::reg_idx_t     o_mem_tgt,
    output logic                  o_reg_wr_en,
    output rsc_pkg::mem_wb_t      o_wb
);

    rsc_pkg::mem_wb_t r_mem;       // Result field holds the ALU value
    logic             r_mem_load;

    // Data port straight from the execute/memory register
    assign o_mem_addr    = i_ex_mem.alu_result;
    assign o_mem_wr_data = i_ex_mem.st_data;
    assign o_mem_wr_en   = i_ex_mem.valid && i_ex_mem.opcode == rsc_pkg::OP_SW;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_mem.valid <= 1'b0;
            r_mem_load  <= 1'b0;
            o_wb.valid  <= 1'b0;
        end else begin
            r_mem      <= '{valid: i_ex_mem.valid, tgt: i_ex_mem.tgt,
                            result: i_ex_mem.alu_result};
            r_mem_load <= i_ex_mem.valid && i_ex_mem.opcode == rsc_pkg::OP_LW;
            o_wb       <= '{valid: r_mem.valid, tgt: r_mem.tgt, result: o_mem_result};
        end
    end

    // Read data arrives a cycle after the address
    assign o_mem_result = r_mem_load ? i_mem_rd_data : r_mem.result;
    assign o_mem_tgt    = r_mem.valid ? r_mem.tgt : '0;
    assign o_reg_wr_en  = r_mem.valid && r_mem.tgt != '0;

    // A store moves on without touching the register file
    a_store_no_wr: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_wr_en |=> !o_reg_wr_en);

endmodule

`default_nettype wire

// File: hw/rsc_pkg.sv
`default_nettype none

`include "rsc_macros.svh"

package rsc_pkg;

    typedef logic [`RSC_WORD_W-1:0]    word_t;
    typedef logic [`RSC_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [`RSC_OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_ADDI = 3'd1,
        OP_NAND = 3'd2,
        OP_LUI  = 3'd3,
        OP_SW   = 3'd4,
        OP_LW   = 3'd5,
        OP_BEQ  = 3'd6,
        OP_JALR = 3'd7
    } opcode_e;

    // Fetch to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        opcode_e  opcode;
        reg_idx_t tgt;
        reg_idx_t src1;
        reg_idx_t src2;
        word_t    opnd1;     // Register read, may be stale
        word_t    opnd2;
        word_t    imm;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic     valid;
        word_t    pc;
        opcode_e  opcode;
        reg_idx_t tgt;
        word_t    alu_result;
        word_t    st_data;
        logic     eq;
        word_t    imm;
    } ex_mem_t;

    // Memory stage and write-back
    typedef struct packed {
        logic     valid;
        reg_idx_t tgt;
        word_t    result;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rsc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsc_macros.svh"

module rsc_regfile (
    input  wire logic              i_clk,
    input  wire rsc_pkg::reg_idx_t i_rd_idx1,
    input  wire rsc_pkg::reg_idx_t i_rd_idx2,
    output rsc_pkg::word_t         o_rd_data1,
    output rsc_pkg::word_t         o_rd_data2,
    input  wire logic              i_wr_en,
    input  wire rsc_pkg::reg_idx_t i_wr_idx,
    input  wire rsc_pkg::word_t    i_wr_data
);

    rsc_pkg::word_t r_regs [`RSC_NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_wr_en && i_wr_idx != '0) begin
            r_regs[i_wr_idx] <= i_wr_data;
        end
    end

    // Entry 0 is never written, so mask it on read
    assign o_rd_data1 = (i_rd_idx1 == '0) ? '0 : r_regs[i_rd_idx1];
    assign o_rd_data2 = (i_rd_idx2 == '0) ? '0 : r_regs[i_rd_idx2];

    // No write ever targets r0
    a_r0_no_write: assert property (@(posedge i_clk)
        i_wr_en |-> i_wr_idx != '0);

endmodule

`default_nettype wire

// File: rsc_core.f
+incdir+hw
hw/rsc_pkg.sv
hw/rsc_fetch.sv
hw/rsc_regfile.sv
hw/rsc_decode.sv
hw/rsc_execute.sv
hw/rsc_mem_wb.sv
hw/rsc_hazard_ctrl.sv
hw/rsc_core.sv
sim/tb_rsc_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rsc_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rsc_core -Mdir obj_dir -f rsc_core.f

./obj_dir/Vtb_rsc_core | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: sim/tb_rsc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsc_macros.svh"

module tb_rsc_core;

    localparam int RST_CYCLES = 16;

    logic           i_clk;
    logic           i_rst;
    rsc_pkg::word_t i_inst;
    rsc_pkg::word_t o_pc;
    rsc_pkg::word_t i_mem_rd_data;
    rsc_pkg::word_t o_mem_addr;
    rsc_pkg::word_t o_mem_wr_data;
    logic           o_mem_wr_en;

    rsc_pkg::word_t rom [256];
    rsc_pkg::word_t ram [256];
    rsc_pkg::word_t exp_ram [256];
    logic [7:0]     ram_rd_addr = 8'h00;
    rsc_pkg::word_t exp_addr [$];
    rsc_pkg::word_t exp_data [$];
    int             prog_len;
    int             seen;
    int             errors = 0;
    int             total_stores = 0;
    int             cycles = 0;
    int             limit = 0;
    int             seed = 32'hab6d;
    string          cur_test = "none";

    rsc_core dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_inst        (i_inst),
        .o_pc          (o_pc),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    assign i_inst        = rom[o_pc[7:0]];        // Combinational fetch
    assign i_mem_rd_data = ram[ram_rd_addr];

    always @(posedge i_clk) begin
        if (o_mem_wr_en)
            ram[o_mem_addr[7:0]] <= o_mem_wr_data;
        ram_rd_addr <= o_mem_addr[7:0];           // Registered read address
    end

    function automatic rsc_pkg::word_t fill_word(input int addr);
        logic [7:0] a;
        a = addr[7:0];
        return {a, ~a ^ 8'h3c};
    endfunction

    // --------------------------------------------------
    // Program builder
    // --------------------------------------------------
    function automatic rsc_pkg::word_t enc_rrr(input rsc_pkg::opcode_e op, input int ra,
                                               input int rb, input int rc);
        return {op, ra[2:0], rb[2:0], 4'b0000, rc[2:0]};
    endfunction

    function automatic rsc_pkg::word_t enc_rri(input rsc_pkg::opcode_e op, input int ra,
                                               input int rb, input int imm);
        return {op, ra[2:0], rb[2:0], imm[6:0]};
    endfunction

    task automatic emit(input rsc_pkg::word_t inst);
        rom[prog_len] = inst;
        prog_len++;
    endtask

    // Reset the core, then give every register a known value
    task automatic begin_test(input string name);
        @(posedge i_clk);
        #1 i_rst = 1'b1;
        cur_test = name;
        prog_len = 0;
        for (int i = 0; i < 256; i++)
            rom[i] = enc_rri(rsc_pkg::OP_BEQ, 0, 0, -1);
        for (int r = 1; r < `RSC_NUM_REGS; r++)
            emit(enc_rri(rsc_pkg::OP_ADDI, r, 0, r * 3));
    endtask

    // --------------------------------------------------
    // Sequential ISA model, fills the expected stores and RAM
    // --------------------------------------------------
    function automatic int run_model();
        rsc_pkg::word_t   regs [`RSC_NUM_REGS];
        rsc_pkg::word_t   pc;
        rsc_pkg::word_t   next_pc;
        rsc_pkg::word_t   inst;
        rsc_pkg::word_t   simm;
        rsc_pkg::word_t   addr;
        rsc_pkg::opcode_e op;
        int               ra;
        int               rb;
        int               rc;
        int               steps;
        for (int r = 0; r < `RSC_NUM_REGS; r++)
            regs[r] = '0;
        for (int i = 0; i < 256; i++)
            exp_ram[i] = fill_word(i);
        exp_addr.delete();
        exp_data.delete();
        pc    = '0;
        steps = 0;
        while (steps < 2000) begin
            inst    = rom[pc[7:0]];
            op      = rsc_pkg::opcode_e'(inst[15:13]);
            ra      = int'(inst[12:10]);
            rb      = int'(inst[9:7]);
            rc      = int'(inst[2:0]);
            simm    = {{9{inst[6]}}, inst[6:0]};
            addr    = regs[rb] + simm;
            next_pc = pc + 16'd1;
            case (op)
                rsc_pkg::OP_ADD:  regs[ra] = regs[rb] + regs[rc];
                rsc_pkg::OP_ADDI: regs[ra] = regs[rb] + simm;
                rsc_pkg::OP_NAND: regs[ra] = ~(regs[rb] & regs[rc]);
                rsc_pkg::OP_LUI:  regs[ra] = {inst[9:0], 6'b000000};
                rsc_pkg::OP_LW:   regs[ra] = exp_ram[addr[7:0]];
                rsc_pkg::OP_SW: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[ra]);
                    exp_ram[addr[7:0]] = regs[ra];
                end
                rsc_pkg::OP_BEQ: begin
                    if (regs[ra] == regs[rb])
                        next_pc = pc + 16'd1 + simm;
                end
                default: begin                    // JALR reads the base before linking
                    next_pc  = regs[rb];
                    regs[ra] = pc + 16'd1;
                end
            endcase
            regs[0] = '0;
            if (next_pc == pc)
                break;                            // Halt loop reached
            pc = next_pc;
            steps++;
        end
        return steps;
    endfunction

    // --------------------------------------------------
    // Compare tasks and store monitor
    // --------------------------------------------------
    task automatic check_addr(input rsc_pkg::word_t exp, input rsc_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s address: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_data(input rsc_pkg::word_t exp, input rsc_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("mismatch %s data: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_rst && o_mem_wr_en) begin
            if (seen < exp_addr.size()) begin
                check_addr(exp_addr[seen], o_mem_addr);
                check_data(exp_data[seen], o_mem_wr_data);
            end else begin
                errors++;
                $display("%s: extra store to address %h that the program never executes",
                         cur_test, o_mem_addr);
            end
            seen++;
            total_stores++;
        end
    end

    // Ends a run that never reaches its halt loop
    initial begin
        wait (cycles > limit);
        errors++;
        $display("%s: timed out after %0d cycles without reaching the halt loop",
                 cur_test, cycles);
        $display("errors: %0d, stores seen: %0d", errors, total_stores);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Release reset and run until the halt BEQ has executed once
    task automatic run_test();
        rsc_pkg::word_t halt_pc;
        int             hits;
        logic           at_halt;
        logic           was_at_halt;
        emit(enc_rri(rsc_pkg::OP_BEQ, 0, 0, -1));
        halt_pc = rsc_pkg::word_t'(prog_len - 1);
        void'(run_model());
        for (int i = 0; i < 256; i++)
            ram[i] = fill_word(i);
        seen = 0;
        repeat (RST_CYCLES) @(posedge i_clk);
        #1 i_rst = 1'b0;
        cycles      = 0;
        limit       = 8 * prog_len + RST_CYCLES;
        hits        = 0;
        was_at_halt = 1'b0;
        while (hits < 2) begin
            @(posedge i_clk);
            #1;
            cycles++;
            at_halt = (o_pc == halt_pc);
            if (at_halt && !was_at_halt)
                hits++;                           // Second entry means halt left execute
            was_at_halt = at_halt;
        end
        if (seen < exp_addr.size()) begin
            errors++;
            $display("%s: too few stores, %0d seen and %0d expected",
                     cur_test, seen, exp_addr.size());
        end
        for (int i = 0; i < 256; i++)
            check_data(exp_ram[i], ram[i]);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin
        int r;
        int op_sel;
        i_rst = 1'b1;

        begin_test("alu_forwarding");
        emit(enc_rrr(rsc_pkg::OP_ADD, 1, 2, 3));
        emit(enc_rri(rsc_pkg::OP_ADDI, 4, 1, -5));
        emit(enc_rrr(rsc_pkg::OP_NAND, 5, 4, 1));
        emit({rsc_pkg::OP_LUI, 3'd6, 10'h2d5});
        emit(enc_rrr(rsc_pkg::OP_ADD, 7, 6, 5));
        emit(enc_rrr(rsc_pkg::OP_ADD, 2, 7, 5));  // r5 comes from write-back
        for (int i = 1; i < `RSC_NUM_REGS; i++)
            emit(enc_rri(rsc_pkg::OP_SW, i, 0, 16 + i));
        run_test();

        begin_test("load_use");
        emit(enc_rri(rsc_pkg::OP_ADDI, 1, 0, 40));
        emit(enc_rri(rsc_pkg::OP_ADDI, 5, 0, 9));
        emit(enc_rri(rsc_pkg::OP_LW, 2, 1, 3));
        emit(enc_rrr(rsc_pkg::OP_ADD, 3, 2, 1));  // Load used at once while r1 sits in write-back
        emit(enc_rri(rsc_pkg::OP_SW, 3, 1, 5));
        emit(enc_rri(rsc_pkg::OP_LW, 4, 1, 0));
        emit(enc_rri(rsc_pkg::OP_SW, 4, 0, 30));  // Load as store data
        emit(enc_rri(rsc_pkg::OP_LW, 6, 0, 30));
        emit(enc_rrr(rsc_pkg::OP_NAND, 7, 6, 6));
        emit(enc_rri(rsc_pkg::OP_SW, 7, 0, 31));
        run_test();

        begin_test("branches");
        emit(enc_rri(rsc_pkg::OP_ADDI, 1, 0, 5));
        emit(enc_rri(rsc_pkg::OP_ADDI, 2, 0, 5));
        emit(enc_rri(rsc_pkg::OP_BEQ, 1, 2, 2));  // Taken
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 50));
        emit(enc_rri(rsc_pkg::OP_SW, 2, 0, 51));
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 52));
        emit(enc_rri(rsc_pkg::OP_BEQ, 1, 3, 2));  // Not taken
        emit(enc_rri(rsc_pkg::OP_SW, 2, 0, 53));
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 54));
        run_test();

        begin_test("jalr_link");
        emit(enc_rri(rsc_pkg::OP_ADDI, 1, 0, prog_len + 5));
        emit(enc_rrr(rsc_pkg::OP_JALR, 2, 1, 0));
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 60));
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 61));
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 62));
        emit(enc_rri(rsc_pkg::OP_SW, 2, 0, 63));  // Jump target
        emit(enc_rri(rsc_pkg::OP_SW, 1, 0, 64));
        run_test();

        begin_test("zero_register");
        emit(enc_rri(rsc_pkg::OP_ADDI, 0, 1, 7));
        emit(enc_rrr(rsc_pkg::OP_ADD, 0, 1, 2));
        emit(enc_rri(rsc_pkg::OP_LW, 0, 1, 0));
        emit(enc_rri(rsc_pkg::OP_SW, 0, 0, 70));
        emit(enc_rrr(rsc_pkg::OP_ADD, 3, 0, 0));
        emit(enc_rri(rsc_pkg::OP_SW, 3, 0, 71));
        run_test();

        begin_test("random_program");
        for (int i = 0; i < 40; i++) begin
            r      = $random(seed);
            op_sel = (r >>> 16) & 32'h7;
            case (op_sel)
                0, 1:    emit(enc_rrr(rsc_pkg::OP_ADD, r & 7, (r >> 3) & 7, (r >> 6) & 7));
                2:       emit(enc_rri(rsc_pkg::OP_ADDI, r & 7, (r >> 3) & 7, r >> 6));
                3:       emit(enc_rrr(rsc_pkg::OP_NAND, r & 7, (r >> 3) & 7, (r >> 6) & 7));
                4, 5:    emit(enc_rri(rsc_pkg::OP_LW, r & 7, 0, (r >> 3) & 15));
                default: emit(enc_rri(rsc_pkg::OP_SW, r & 7, 0, (r >> 3) & 15));
            endcase
        end
        run_test();

        $display("errors: %0d, stores seen: %0d", errors, total_stores);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
